// File: flist.f
+incdir+verilog
verilog/fp_format_pkg.sv
verilog/fp_class_pkg.sv
verilog/fp_classify.sv
verilog/fp_preadder.sv
verilog/fp_add_normalize.sv
verilog/fp_adder_top.sv
verification/fp_tb_clock.sv
verification/fp_adder_checker.sv
verification/fp_adder_tb.sv

// File: verification/fp_adder_checker.sv
`timescale 1ns/1ps
`include "fp_config.svh"

module fp_adder_checker
  import fp_format_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  logic [FP_WORD_W-1:0] a,
  input  logic [FP_WORD_W-1:0] b,
  input  logic                 out_valid,
  input  logic [FP_WORD_W-1:0] result,
  output int                   errors,
  output int                   checked,
  output int                   pending    // operand pairs still waiting for a result
);

  // 2^-149 grid, biggest sum is below 2^278
  localparam int GRID_W  = 280;
  localparam int LATENCY = 2;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  // finite magnitude as an exact integer count of 2^-149
  function automatic logic [GRID_W-1:0] grid_mag(input fp_fields_t f);
    logic [GRID_W-1:0] m;
    m = GRID_W'({f.exp != 8'h00, f.frac});   // hidden bit only for normals
    if (f.exp != 8'h00) m = m << (f.exp - 8'd1);
    return m;
  endfunction

  function automatic logic [31:0] ref_sum(input logic [31:0] a_w, input logic [31:0] b_w);
    fp_fields_t        fa;
    fp_fields_t        fb;
    logic              a_nan;
    logic              b_nan;
    logic              a_inf;
    logic              b_inf;
    logic [GRID_W-1:0] ma;
    logic [GRID_W-1:0] mb;
    logic [GRID_W-1:0] mag;
    logic [GRID_W-1:0] shifted;
    logic              sgn;
    int                top;
    int                e;
    fa    = a_w;
    fb    = b_w;
    a_nan = (fa.exp == 8'hff) && (fa.frac != 23'h0);
    b_nan = (fb.exp == 8'hff) && (fb.frac != 23'h0);
    a_inf = (fa.exp == 8'hff) && (fa.frac == 23'h0);
    b_inf = (fb.exp == 8'hff) && (fb.frac == 23'h0);
    if (a_nan || b_nan) return `FP_QNAN;
    if (a_inf && b_inf) return (fa.sign == fb.sign) ? a_w : `FP_QNAN;
    if (a_inf) return a_w;
    if (b_inf) return b_w;
    ma = grid_mag(fa);
    mb = grid_mag(fb);
    if (ma == '0 && mb == '0) return {fa.sign & fb.sign, 31'h0};   // signed zeros
    if (fa.sign == fb.sign) begin
      mag = ma + mb;
      sgn = fa.sign;
    end else if (ma >= mb) begin
      mag = ma - mb;
      sgn = fa.sign;
    end else begin
      mag = mb - ma;
      sgn = fb.sign;
    end
    if (mag == '0) return 32'h0;   // x + (-x)
    top = 0;
    for (int i = 0; i < GRID_W; i++) begin
      if (mag[i]) top = i;
    end
    if (top < 23) return {sgn, 8'h00, mag[22:0]};   // lands on the subnormal grid
    e = top - 22;
    if (e >= 255) return {sgn, `FP_MAX_FIN};
    shifted = mag >> (top - 23);   // drop low bits, toward zero
    return {sgn, 8'(e), shifted[22:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////////////////////////
  logic [31:0] want_q[$];
  logic [63:0] opnd_q[$];   // {a, b} for the error line
  int          stamp_q[$];  // cycle of the strobe
  int          cyc;
  logic [31:0] want;
  logic [63:0] opnd;
  int          stamp;

  initial begin
    errors  = 0;
    checked = 0;
    pending = 0;
    cyc     = 0;
  end

  // registered outputs read before the NBA update, inputs settled since the falling edge
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!reset) begin
      if (out_valid) begin
        if (want_q.size() == 0) begin
          $display("result %08h came out with no operands waiting for it", result);
          errors++;
        end else begin
          want  = want_q.pop_front();
          opnd  = opnd_q.pop_front();
          stamp = stamp_q.pop_front();
          checked++;
          if (cyc != stamp + LATENCY) begin
            $display("result came %0d cycles after its strobe instead of %0d",
                     cyc - stamp, LATENCY);
            errors++;
          end
          if (result !== want) begin
            $display("Fail result expected %08h actual %08h (a %08h b %08h)",
                     want, result, opnd[63:32], opnd[31:0]);
            errors++;
          end
        end
      end
      // overdue entries, nothing came for them
      while (stamp_q.size() != 0 && stamp_q[0] + LATENCY < cyc) begin
        opnd = opnd_q.pop_front();
        void'(want_q.pop_front());
        void'(stamp_q.pop_front());
        $display("no result for operands %08h %08h", opnd[63:32], opnd[31:0]);
        errors++;
      end
      if (in_valid) begin
        want_q.push_back(ref_sum(a, b));
        opnd_q.push_back({a, b});
        stamp_q.push_back(cyc);
      end
    end
    pending <= want_q.size();
  end

endmodule

// File: verification/fp_adder_tb.sv
`timescale 1ns/1ps

module fp_adder_tb
  import fp_format_pkg::*;
();

  localparam int N_NEAR    = 300;
  localparam int N_FAR     = 150;
  localparam int N_SUB     = 150;
  localparam int N_SPEC    = 120;
  localparam int N_TIMING  = 80;
  localparam int MAX_GAP   = 3;    // idle cycles between gapped strobes
  localparam int MAX_SLOTS = N_NEAR + N_FAR + N_SUB + N_SPEC + N_TIMING * (MAX_GAP + 1);
  localparam int CYCLE_LIMIT = MAX_SLOTS + 50;

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  logic [FP_WORD_W-1:0] a;
  logic [FP_WORD_W-1:0] b;
  logic                 out_valid;
  logic [FP_WORD_W-1:0] result;
  int                   errors;
  int                   checked;
  int                   pending;
  int                   sent;
  int                   err_mark;   // error count at the start of a test
  int                   cycles;

  fp_tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(10)) i_clock (.clk(clk), .reset(reset));

  fp_adder_top i_dut (
    .clk(clk), .reset(reset), .in_valid(in_valid), .a(a), .b(b),
    .out_valid(out_valid), .result(result)
  );

  fp_adder_checker i_checker (
    .clk(clk), .reset(reset), .in_valid(in_valid), .a(a), .b(b),
    .out_valid(out_valid), .result(result),
    .errors(errors), .checked(checked), .pending(pending)
  );

  ////////////////////////////////////////////////////////////
  // operand generators
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] normal_word(input logic sgn, input int e);
    return {sgn, 8'(e), 23'($urandom)};
  endfunction

  function automatic logic [31:0] subnormal_word(input logic sgn);
    logic [22:0] f;
    f = 23'($urandom);
    if (f == 23'h0) f = 23'h1;   // keep it off zero
    return {sgn, 8'h00, f};
  endfunction

  // 0 zero, 1 subnormal, 2 normal, 3 infinity, 4 nan
  function automatic logic [31:0] class_word(input int kind);
    logic        sgn;
    logic [22:0] f;
    sgn = 1'($urandom);
    f   = 23'($urandom);
    if (f == 23'h0) f = 23'h1;
    case (kind)
      0:       return {sgn, 31'h0};
      1:       return {sgn, 8'h00, f};
      2:       return {sgn, 8'(1 + $urandom % 254), f};
      3:       return {sgn, 8'hff, 23'h0};
      default: return {sgn, 8'hff, f};   // quiet or signaling payload
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // drive tasks, all on the falling edge
  ////////////////////////////////////////////////////////////
  task automatic drive_pair(input logic [31:0] x, input logic [31:0] y);
    @(negedge clk);
    in_valid = 1'b1;
    a        = x;
    b        = y;
    sent++;
  endtask

  task automatic hold_idle();
    @(negedge clk);
    in_valid = 1'b0;
    a        = $urandom;   // junk, must be ignored
    b        = $urandom;
  endtask

  task automatic report_test(input string name, input int n);
    hold_idle();
    while (pending != 0) @(negedge clk);   // let the pipe drain
    $display("test %s: %0d vectors, %0d errors", name, n, errors - err_mark);
    err_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    int          ea;
    int          eb;
    int          k;
    logic        s;
    logic [31:0] x;
    logic [31:0] y;
    logic [30:0] mask;
    void'($urandom(32'h2b5a));
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    sent     = 0;
    err_mark = 0;
    @(negedge clk);
    while (reset) @(negedge clk);

    // near exponents, every 4th pair nearly cancels
    for (int i = 0; i < N_NEAR; i++) begin
      ea = 1 + int'($urandom % 254);
      eb = ea + int'($urandom % 61) - 30;
      if (eb < 1) eb = 1;
      if (eb > 254) eb = 254;
      x = normal_word(1'($urandom), ea);
      if (i % 4 == 0) begin
        mask = (31'd1 << ($urandom % 24)) - 31'd1;
        y    = {~x[31], x[30:0] ^ (31'($urandom) & mask)};
      end else begin
        y = normal_word(1'($urandom), eb);
      end
      drive_pair(x, y);
    end
    report_test("near exponents", N_NEAR);

    // far exponents and exact cancellation
    for (int i = 0; i < N_FAR; i++) begin
      ea = 60 + int'($urandom % 195);
      eb = ea - 25 - int'($urandom % 35);   // stays >= 1
      x  = normal_word(1'($urandom), ea);
      y  = (i % 5 == 0) ? (x ^ 32'h8000_0000) : normal_word(1'($urandom), eb);
      if (i % 2 == 1) drive_pair(y, x);
      else drive_pair(x, y);
    end
    report_test("far exponents", N_FAR);

    // subnormals, mixed pairs, underflow
    for (int i = 0; i < N_SUB; i++) begin
      s = 1'($urandom);
      case (i % 3)
        0: begin
          x = subnormal_word(s);
          y = subnormal_word(1'($urandom));
        end
        1: begin
          x = subnormal_word(s);
          y = normal_word(1'($urandom), 1 + int'($urandom % 30));
        end
        default: begin
          x = normal_word(s, 1 + int'($urandom % 2));
          y = normal_word(~s, 1 + int'($urandom % 2));   // difference drops below 2^-126
        end
      endcase
      drive_pair(x, y);
    end
    report_test("subnormals", N_SUB);

    // specials, signed zeros first
    drive_pair(32'h8000_0000, 32'h8000_0000);
    drive_pair(32'h0000_0000, 32'h8000_0000);
    drive_pair(32'h7f80_0000, 32'hff80_0000);
    drive_pair(32'hff80_0000, 32'hff80_0000);
    for (int i = 4; i < N_SPEC; i++) begin
      drive_pair(class_word(int'($urandom % 5)), class_word(int'($urandom % 5)));
    end
    report_test("special classes", N_SPEC);

    // overflow, back to back then gapped
    for (int i = 0; i < N_TIMING; i++) begin
      s = 1'($urandom);
      x = normal_word(s, 252 + int'($urandom % 3));
      y = normal_word(s, 252 + int'($urandom % 3));
      drive_pair(x, y);
      if (i >= N_TIMING / 2) begin
        k = int'($urandom % (MAX_GAP + 1));
        repeat (k) hold_idle();
      end
    end
    report_test("overflow and timing", N_TIMING);

    $display("summary: %0d sent, %0d checked, %0d errors", sent, checked, errors);
    if (errors == 0 && checked == sent) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////
  initial cycles = 0;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

endmodule

// File: verification/fp_tb_clock.sv
`timescale 1ns/1ps

module fp_tb_clock #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // sync reset, released away from the rising edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// File: verilog/fp_add_normalize.sv
`timescale 1ns/1ps
`include "fp_config.svh"

module fp_add_normalize
  import fp_format_pkg::*;
  import fp_class_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  s1_valid,
  input  logic                  big_sign,
  input  logic [`FP_EXP_W-1:0]  big_exp,
  input  logic [`FP_EXT_W-1:0]  big_mant,
  input  logic [`FP_EXT_W-1:0]  small_mant,
  input  logic                  eff_sub,
  input  fp_special_e           special,
  input  logic                  special_sign,
  output logic                  out_valid,
  output logic [FP_WORD_W-1:0]  result
);

  localparam int EXT_W = `FP_EXT_W;
  localparam int EXP_W = `FP_EXP_W;
  localparam int LZ_W  = $clog2(EXT_W + 1);
  localparam int LOW_W = EXT_W - `FP_FRAC_W - 1;   // bits dropped by truncation

  // leading zeros of the working mantissa or EXT_W when all clear
  function automatic logic [LZ_W-1:0] count_lz(input logic [EXT_W-1:0] v);
    logic [LZ_W-1:0] n;
    logic            found;
    n     = LZ_W'(EXT_W);
    found = 1'b0;
    for (int i = EXT_W - 1; i >= 0; i--) begin
      if (!found && v[i]) begin
        n     = LZ_W'(EXT_W - 1 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // add or subtract
  ////////////////////////////////////////////////////////////
  logic [EXT_W:0] sum;      // one extra bit for the carry
  logic           carry;
  logic           sum_zero;

  assign sum = eff_sub ? ({1'b0, big_mant} - {1'b0, small_mant})   // big >= small
                       : ({1'b0, big_mant} + {1'b0, small_mant});
  assign carry    = sum[EXT_W];
  assign sum_zero = ~|sum;

  ////////////////////////////////////////////////////////////
  // normalize
  ////////////////////////////////////////////////////////////
  logic [LZ_W-1:0]  lz;
  logic [EXP_W-1:0] shift_lim;    // left shift that still keeps exponent >= 1
  logic [EXP_W-1:0] shift_l;
  logic [EXT_W-1:0] norm;
  logic [EXP_W:0]   exp_n;        // 9 bits to catch 255 and above
  logic             ovf;

  assign lz        = count_lz(sum[EXT_W-1:0]);
  assign shift_lim = big_exp - EXP_W'(1);
  assign shift_l   = (EXP_W'(lz) > shift_lim) ? shift_lim : EXP_W'(lz);   // stop at subnormal

  always_comb begin
    if (carry) begin
      norm  = {sum[EXT_W:2], sum[1] | sum[0]};   // right by one keeping sticky
      exp_n = {1'b0, big_exp} + (EXP_W+1)'(1);
    end else begin
      norm  = sum[EXT_W-1:0] << shift_l;
      exp_n = {1'b0, big_exp} - {1'b0, shift_l};
    end
  end

  assign ovf = (exp_n >= (EXP_W+1)'(255));

  ////////////////////////////////////////////////////////////
  // pack and pick the result
  ////////////////////////////////////////////////////////////
  fp_fields_t           arith;
  logic [FP_WORD_W-1:0] result_c;

  // hidden bit clear after a limited shift means subnormal with stored exp 0
  assign arith.sign = big_sign;
  assign arith.exp  = norm[EXT_W-1] ? exp_n[EXP_W-1:0] : '0;
  assign arith.frac = norm[EXT_W-2:LOW_W];   // truncate guard and sticky toward zero

  always_comb begin
    case (special)
      SPC_QNAN: result_c = `FP_QNAN;
      SPC_INF:  result_c = {special_sign, {EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};
      SPC_ZERO: result_c = {special_sign, {(FP_WORD_W-1){1'b0}}};
      default: begin
        if (sum_zero) begin
          result_c = '0;                        // exact cancellation gives +0
        end else if (ovf) begin
          result_c = {big_sign, `FP_MAX_FIN};   // saturate since rtz never reaches inf
        end else begin
          result_c = arith;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // stage 2 registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result <= result_c;
    end
  end

  // pre-adder ordering keeps the magnitude subtraction from going negative
  a_sub_ordered : assert property (@(posedge clk) disable iff (reset)
    (s1_valid && eff_sub && (special == SPC_NONE)) |-> (big_mant >= small_mant));

endmodule

// File: verilog/fp_adder_top.sv
`timescale 1ns/1ps
`include "fp_config.svh"

module fp_adder_top
  import fp_format_pkg::*;
  import fp_class_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  logic [FP_WORD_W-1:0] a,
  input  logic [FP_WORD_W-1:0] b,
  output logic                 out_valid,
  output logic [FP_WORD_W-1:0] result    // two cycles after in_valid
);

  ////////////////////////////////////////////////////////////
  // classifier outputs, combinational
  ////////////////////////////////////////////////////////////
  fp_class_e            a_cls;
  fp_class_e            b_cls;
  logic                 a_sign;
  logic                 b_sign;
  logic [`FP_EXP_W-1:0] a_exp;
  logic [`FP_EXP_W-1:0] b_exp;
  logic [`FP_EXT_W-1:0] a_mant;
  logic [`FP_EXT_W-1:0] b_mant;

  // stage 1 register outputs
  logic                 s1_valid;
  logic                 big_sign;
  logic [`FP_EXP_W-1:0] big_exp;
  logic [`FP_EXT_W-1:0] big_mant;
  logic [`FP_EXT_W-1:0] small_mant;
  logic                 eff_sub;
  fp_special_e          special;
  logic                 special_sign;

  fp_classify i_class_a (.word(a), .cls(a_cls), .sign(a_sign), .exp_eff(a_exp), .mant(a_mant));
  fp_classify i_class_b (.word(b), .cls(b_cls), .sign(b_sign), .exp_eff(b_exp), .mant(b_mant));

  fp_preadder i_preadder (
    .clk(clk), .reset(reset), .in_valid(in_valid),
    .a_word(a), .b_word(b),
    .a_cls(a_cls), .b_cls(b_cls), .a_sign(a_sign), .b_sign(b_sign),
    .a_exp(a_exp), .b_exp(b_exp), .a_mant(a_mant), .b_mant(b_mant),
    .s1_valid(s1_valid), .big_sign(big_sign),
    .small_sign(),                          // sign difference already in eff_sub
    .big_exp(big_exp), .big_mant(big_mant), .small_mant(small_mant),
    .eff_sub(eff_sub), .special(special), .special_sign(special_sign)
  );

  fp_add_normalize i_add_norm (
    .clk(clk), .reset(reset), .s1_valid(s1_valid),
    .big_sign(big_sign), .big_exp(big_exp), .big_mant(big_mant), .small_mant(small_mant),
    .eff_sub(eff_sub), .special(special), .special_sign(special_sign),
    .out_valid(out_valid), .result(result)
  );

endmodule

// File: verilog/fp_class_pkg.sv
package fp_class_pkg;

  // operand class codes
  typedef enum logic [2:0] {
    CLS_ZERO = 3'b000,
    CLS_SUB  = 3'b001,   // subnormal
    CLS_INF  = 3'b010,
    CLS_NAN  = 3'b011,
    CLS_NORM = 3'b100
  } fp_class_e;

  // where the final word comes from
  typedef enum logic [1:0] {
    SPC_NONE = 2'b00,   // arithmetic path
    SPC_QNAN = 2'b01,   // canonical quiet nan
    SPC_INF  = 2'b10,   // signed infinity
    SPC_ZERO = 2'b11    // signed zero
  } fp_special_e;

  function automatic fp_special_e special_src(input fp_class_e a_cls, input fp_class_e b_cls,
                                              input logic a_sign, input logic b_sign);
    logic any_nan;
    logic inf_clash;
    any_nan   = (a_cls == CLS_NAN) || (b_cls == CLS_NAN);
    inf_clash = (a_cls == CLS_INF) && (b_cls == CLS_INF) && (a_sign != b_sign);
    if (any_nan || inf_clash) return SPC_QNAN;
    if ((a_cls == CLS_INF) || (b_cls == CLS_INF)) return SPC_INF;
    if ((a_cls == CLS_ZERO) && (b_cls == CLS_ZERO)) return SPC_ZERO;
    return SPC_NONE;
  endfunction

  // sign of the special word, meaningless for nan
  function automatic logic special_sgn(input fp_class_e a_cls, input fp_class_e b_cls,
                                       input logic a_sign, input logic b_sign);
    if (a_cls == CLS_INF) return a_sign;
    if (b_cls == CLS_INF) return b_sign;
    return a_sign & b_sign;   // -0 only from -0 + -0
  endfunction

endpackage

// File: verilog/fp_classify.sv
`timescale 1ns/1ps
`include "fp_config.svh"

module fp_classify
  import fp_format_pkg::*;
  import fp_class_pkg::*;
(
  input  fp_word_u              word,
  output fp_class_e             cls,
  output logic                  sign,
  output logic [`FP_EXP_W-1:0]  exp_eff,   // stored exponent, 1 for subnormal
  output logic [`FP_EXT_W-1:0]  mant       // hidden, fraction, zero low bits
);

  localparam int LOW_W = `FP_EXT_W - `FP_FRAC_W - 1;   // guard + sticky slots

  ////////////////////////////////////////////////////////////
  // field decode
  ////////////////////////////////////////////////////////////
  logic exp_zero;
  logic exp_ones;
  logic frac_zero;
  logic hidden;

  assign exp_zero  = ~|word.fld.exp;
  assign exp_ones  = &word.fld.exp;
  assign frac_zero = ~|word.fld.frac;

  always_comb begin
    if (exp_zero && frac_zero) begin
      cls = CLS_ZERO;
    end else if (exp_zero) begin
      cls = CLS_SUB;            // no hidden bit
    end else if (exp_ones && frac_zero) begin
      cls = CLS_INF;
    end else if (exp_ones) begin
      cls = CLS_NAN;            // any payload, quiet or signaling
    end else begin
      cls = CLS_NORM;
    end
  end

  assign sign = word.fld.sign;

  ////////////////////////////////////////////////////////////
  // effective exponent and mantissa
  ////////////////////////////////////////////////////////////
  // subnormals sit on the exponent 1 grid with hidden bit 0,
  // so they align exactly like normals downstream
  assign exp_eff = exp_zero ? `FP_EXP_W'(1) : word.fld.exp;
  assign hidden  = (cls == CLS_NORM);   // inf and nan keep it clear, overridden later

  assign mant = {hidden, word.fld.frac, {LOW_W{1'b0}}};

endmodule

// File: verilog/fp_config.svh
`ifndef FP_CONFIG_SVH
`define FP_CONFIG_SVH

////////////////////////////////////////////////////////////
// binary32 field widths
////////////////////////////////////////////////////////////
`define FP_EXP_W   8    // biased exponent
`define FP_FRAC_W  23   // stored fraction, hidden bit not counted

// working mantissa: hidden, fraction, 3 guard, 1 sticky
`define FP_EXT_W   28

////////////////////////////////////////////////////////////
// fixed result words
////////////////////////////////////////////////////////////
`define FP_QNAN    32'h7fc00000   // canonical quiet nan, sign clear
`define FP_MAX_FIN 31'h7f7fffff   // largest finite magnitude, sign added later

`endif

// File: verilog/fp_format_pkg.sv
`include "fp_config.svh"

package fp_format_pkg;

  // word split into its ieee fields
  typedef struct packed {
    logic                  sign;
    logic [`FP_EXP_W-1:0]  exp;   // biased
    logic [`FP_FRAC_W-1:0] frac;
  } fp_fields_t;

  // same word, exponent and fraction read as one unsigned integer
  // magnitudes of binary32 values order like these integers
  typedef struct packed {
    logic                            sign;
    logic [`FP_EXP_W+`FP_FRAC_W-1:0] mag;
  } fp_mag_t;

  // two views of one operand word
  typedef union packed {
    fp_fields_t fld;   // decoded by the classifier
    fp_mag_t    num;   // compared by the pre-adder
  } fp_word_u;

  localparam int FP_WORD_W = $bits(fp_word_u);   // 32

endpackage

// File: verilog/fp_preadder.sv
`timescale 1ns/1ps
`include "fp_config.svh"

module fp_preadder
  import fp_format_pkg::*;
  import fp_class_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  fp_word_u              a_word,
  input  fp_word_u              b_word,
  input  fp_class_e             a_cls,
  input  fp_class_e             b_cls,
  input  logic                  a_sign,
  input  logic                  b_sign,
  input  logic [`FP_EXP_W-1:0]  a_exp,
  input  logic [`FP_EXP_W-1:0]  b_exp,
  input  logic [`FP_EXT_W-1:0]  a_mant,
  input  logic [`FP_EXT_W-1:0]  b_mant,
  output logic                  s1_valid,
  output logic                  big_sign,
  output logic                  small_sign,
  output logic [`FP_EXP_W-1:0]  big_exp,
  output logic [`FP_EXT_W-1:0]  big_mant,
  output logic [`FP_EXT_W-1:0]  small_mant,  // aligned, sticky in bit 0
  output logic                  eff_sub,
  output fp_special_e           special,
  output logic                  special_sign
);

  localparam int EXT_W = `FP_EXT_W;
  localparam int SH_W  = $clog2(EXT_W + 1);   // holds 0..28

  ////////////////////////////////////////////////////////////
  // magnitude order
  ////////////////////////////////////////////////////////////
  logic                 a_ge_b;
  logic                 big_sign_c;
  logic                 small_sign_c;
  logic [`FP_EXP_W-1:0] big_exp_c;
  logic [`FP_EXP_W-1:0] small_exp_c;
  logic [EXT_W-1:0]     big_mant_c;
  logic [EXT_W-1:0]     small_mant_c;

  // one integer compare replaces exponent-then-mantissa ordering,
  // effective exponents keep subnormal and mixed pairs on the same path
  assign a_ge_b = (a_word.num.mag >= b_word.num.mag);

  assign big_sign_c   = a_ge_b ? a_sign : b_sign;
  assign small_sign_c = a_ge_b ? b_sign : a_sign;
  assign big_exp_c    = a_ge_b ? a_exp  : b_exp;
  assign small_exp_c  = a_ge_b ? b_exp  : a_exp;
  assign big_mant_c   = a_ge_b ? a_mant : b_mant;
  assign small_mant_c = a_ge_b ? b_mant : a_mant;

  ////////////////////////////////////////////////////////////
  // align smaller operand
  ////////////////////////////////////////////////////////////
  logic [`FP_EXP_W-1:0] exp_diff;
  logic [SH_W-1:0]      shift_amt;
  logic [EXT_W-1:0]     lost_mask;
  logic [EXT_W-1:0]     shifted;
  logic                 sticky;
  logic [EXT_W-1:0]     aligned;

  assign exp_diff  = big_exp_c - small_exp_c;   // never negative after ordering
  assign shift_amt = (exp_diff > `FP_EXP_W'(EXT_W)) ? SH_W'(EXT_W)
                                                     : exp_diff[SH_W-1:0];   // clamp

  assign shifted   = small_mant_c >> shift_amt;
  assign lost_mask = ~({EXT_W{1'b1}} << shift_amt);   // bits that fall off the end
  assign sticky    = |(small_mant_c & lost_mask);
  assign aligned   = {shifted[EXT_W-1:1], shifted[0] | sticky};

  ////////////////////////////////////////////////////////////
  // special classes
  ////////////////////////////////////////////////////////////
  fp_special_e special_c;
  logic        special_sign_c;

  assign special_c      = special_src(a_cls, b_cls, a_sign, b_sign);
  assign special_sign_c = special_sgn(a_cls, b_cls, a_sign, b_sign);

  ////////////////////////////////////////////////////////////
  // stage 1 registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // payload only moves with a strobe
  always_ff @(posedge clk) begin
    if (in_valid) begin
      big_sign     <= big_sign_c;
      small_sign   <= small_sign_c;
      big_exp      <= big_exp_c;
      big_mant     <= big_mant_c;
      small_mant   <= aligned;
      eff_sub      <= a_sign ^ b_sign;   // signs differ, subtract magnitudes
      special      <= special_c;
      special_sign <= special_sign_c;
    end
  end

  // larger operand never carries the smaller exponent
  a_big_exp_ge : assert property (@(posedge clk) disable iff (reset)
    s1_valid |-> (big_exp >= $past(small_exp_c)));

endmodule
